//--- hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and instruction width
`define XLEN 32

// Byte address into either memory
`define ADDR_W 16

// Register file shape
`define REG_COUNT 32
`define REG_AW 5

// First fetch address out of reset
`define PC_START 512

`endif

//--- hdl/corePkg.sv
`include "core_defines.svh"

package corePkg;

	// Primary opcode, instr[31:26]; anything else behaves as a no-op
	typedef enum logic [5:0] {
		OP_ALU    = 6'b000001, // rd = rs1 op rs2
		OP_ALUI   = 6'b000010, // rd = rs1 op imm
		OP_LOAD   = 6'b000011,
		OP_STORE  = 6'b100011, // Data source sits in the rd field
		OP_BRANCH = 6'b000100, // Taken when ALU bit 0 set
		OP_JUMP   = 6'b000101
	} opcodeT;

	// ALU function codes, instr[3:0]
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b0001,
		ALU_SLL = 4'b0010,
		ALU_SRL = 4'b0011,
		ALU_SRA = 4'b0100,
		ALU_OR  = 4'b0101,
		ALU_GE  = 4'b0110,
		ALU_XOR = 4'b0111,
		ALU_SLT = 4'b1000,
		ALU_EQ  = 4'b1001,
		ALU_NE  = 4'b1101,
		ALU_AND = 4'b1111
	} aluFuncT;

	// Load/store access size, instr[2:0]
	typedef enum logic [2:0] {
		WORD = 3'b000,
		HALF = 3'b001,
		BYTE = 3'b010
	} memWidthT;

	typedef struct packed {
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc; // Operand B from imm
		logic branch;
		logic jump;
		logic [`XLEN-1:0] pcPlus4;
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB;
		logic [`XLEN-1:0] imm;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2; // Second source, whichever field named it
		aluFuncT aluFunc;
		memWidthT width;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic [`XLEN-1:0] aluResult; // Also the data address
		logic [`XLEN-1:0] storeData;
		logic [`REG_AW-1:0] rd;
		memWidthT width;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] loadData;
		logic [`REG_AW-1:0] rd;
	} memWbT;

	typedef struct packed {
		logic valid;
		logic write; // 1 store, 0 load
		logic [`ADDR_W-1:0] addr;
		logic [`XLEN-1:0] wdata;
		logic [3:0] byteEn;
	} dmemReqT;

endpackage

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module fetchStage (
	input  logic clk,
	input  logic reset,
	input  logic memStall,
	input  logic stall, // Load-use hold from decode
	input  logic redirect,
	input  logic [`XLEN-1:0] target,
	input  logic [`XLEN-1:0] imemData,
	output logic [`ADDR_W-1:0] imemAddr,
	output logic imemValid,
	output corePkg::ifIdT ifId
);
	import corePkg::*;

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] fetchWord; // Instruction in core byte order

	// Memory returns little-endian bytes, swap back
	assign fetchWord = {imemData[7:0], imemData[15:8], imemData[23:16], imemData[31:24]};
	assign imemAddr = pc[`ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `XLEN'(`PC_START);
			imemValid <= 1'b0;
			ifId.instr <= '0; // All-zero word decodes as no-op
		end else begin
			imemValid <= 1'b1;
			if (!memStall) begin // Frozen on cache miss
				if (redirect) begin
					pc <= target;
					ifId.instr <= '0; // Kill the wrong-path fetch
				end else if (!stall) begin
					pc <= pc + `XLEN'(4);
					ifId.instr <= fetchWord;
					ifId.pcPlus4 <= pc + `XLEN'(4);
				end
			end
		end
	end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decodeStage (
	input  logic clk,
	input  logic reset,
	input  logic memStall,
	input  logic squash, // Taken branch/jump in execute
	input  corePkg::ifIdT ifId,
	input  logic wbEn,
	input  logic [`REG_AW-1:0] wbRd,
	input  logic [`XLEN-1:0] wbData,
	output logic stall,
	output corePkg::idExT idEx
);
	import corePkg::*;

	logic [`XLEN-1:0] regFile [`REG_COUNT];
	opcodeT opcode;
	logic [`REG_AW-1:0] rdField;
	logic [`REG_AW-1:0] rs1Field;
	logic [`REG_AW-1:0] src2; // rs2, or rd field for store/branch
	logic useRs1;
	logic useRs2;
	logic [`XLEN-1:0] rdata1;
	logic [`XLEN-1:0] rdata2;
	idExT idExNext;

	assign opcode = opcodeT'(ifId.instr[31:26]);
	assign rdField = ifId.instr[25:21];
	assign rs1Field = ifId.instr[20:16];
	assign src2 = (opcode == OP_STORE || opcode == OP_BRANCH) ? rdField : ifId.instr[15:11];

	// Which sources the instruction really reads
	assign useRs1 = opcode inside {OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH};
	assign useRs2 = opcode inside {OP_ALU, OP_STORE, OP_BRANCH};

	// Register 0 hardwired, same-cycle writeback bypassed
	assign rdata1 = (rs1Field == '0) ? '0 :
		(wbEn && wbRd == rs1Field) ? wbData : regFile[rs1Field];
	assign rdata2 = (src2 == '0) ? '0 :
		(wbEn && wbRd == src2) ? wbData : regFile[src2];

	// Loaded value not ready until MEM/WB
	assign stall = idEx.memRead &&
		((useRs1 && idEx.rd == rs1Field) || (useRs2 && idEx.rd == src2));

	always_comb begin
		idExNext = '0;
		idExNext.pcPlus4 = ifId.pcPlus4;
		idExNext.opA = rdata1;
		idExNext.opB = rdata2;
		idExNext.imm = {{(`XLEN-12){ifId.instr[15]}}, ifId.instr[15:4]}; // 12-bit signed
		idExNext.rd = rdField;
		idExNext.rs1 = rs1Field;
		idExNext.rs2 = src2;
		idExNext.aluFunc = aluFuncT'(ifId.instr[3:0]);
		idExNext.width = memWidthT'(ifId.instr[2:0]);
		if (!(stall || squash)) begin // Otherwise flags stay zero, a bubble
			case (opcode)
				OP_ALU: idExNext.regWrite = 1'b1;
				OP_ALUI: begin
					idExNext.regWrite = 1'b1;
					idExNext.aluSrc = 1'b1;
				end
				OP_LOAD: begin
					idExNext.regWrite = 1'b1;
					idExNext.memRead = 1'b1;
					idExNext.memToReg = 1'b1;
					idExNext.aluSrc = 1'b1;
					idExNext.aluFunc = ALU_ADD; // Base plus offset
				end
				OP_STORE: begin
					idExNext.memWrite = 1'b1;
					idExNext.aluSrc = 1'b1;
					idExNext.aluFunc = ALU_ADD;
				end
				OP_BRANCH: idExNext.branch = 1'b1; // Compare rs1 with rd field
				OP_JUMP: idExNext.jump = 1'b1;
				default: ; // No-op
			endcase
		end
	end

	// Write keeps going under memStall, MEM/WB is frozen anyway
	always_ff @(posedge clk) begin
		if (wbEn && wbRd != '0)
			regFile[wbRd] <= wbData;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idEx.regWrite <= 1'b0;
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.memToReg <= 1'b0;
			idEx.aluSrc <= 1'b0;
			idEx.branch <= 1'b0;
			idEx.jump <= 1'b0;
		end else if (!memStall) begin
			idEx <= idExNext;
		end
	end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module executeStage (
	input  logic clk,
	input  logic reset,
	input  logic memStall,
	input  corePkg::idExT idEx,
	input  logic wbEn,
	input  logic [`REG_AW-1:0] wbRd,
	input  logic [`XLEN-1:0] wbData,
	output logic redirect,
	output logic [`XLEN-1:0] target,
	output corePkg::exMemT exMem
);
	import corePkg::*;

	logic [`XLEN-1:0] fwdA;
	logic [`XLEN-1:0] fwdB; // Also the store data
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;

	// EX/MEM is younger than MEM/WB so it wins
	function automatic logic [`XLEN-1:0] pickOperand(input logic [`REG_AW-1:0] src,
			input logic [`XLEN-1:0] regVal);
		if (exMem.regWrite && exMem.rd != '0 && exMem.rd == src)
			return exMem.aluResult;
		else if (wbEn && wbRd != '0 && wbRd == src)
			return wbData;
		return regVal;
	endfunction

	always_comb begin
		fwdA = pickOperand(idEx.rs1, idEx.opA);
		fwdB = pickOperand(idEx.rs2, idEx.opB);
	end

	assign opB = idEx.aluSrc ? idEx.imm : fwdB;

	// Compares are unsigned, result in bit 0
	always_comb begin
		case (idEx.aluFunc)
			ALU_ADD: aluResult = fwdA + opB;
			ALU_SUB: aluResult = fwdA - opB;
			ALU_SLL: aluResult = fwdA << opB[4:0];
			ALU_SRL: aluResult = fwdA >> opB[4:0];
			ALU_SRA: aluResult = $signed(fwdA) >>> opB[4:0];
			ALU_OR:  aluResult = fwdA | opB;
			ALU_GE:  aluResult = `XLEN'(fwdA >= opB);
			ALU_XOR: aluResult = fwdA ^ opB;
			ALU_SLT: aluResult = `XLEN'(fwdA < opB);
			ALU_EQ:  aluResult = `XLEN'(fwdA == opB);
			ALU_NE:  aluResult = `XLEN'(fwdA != opB);
			ALU_AND: aluResult = fwdA & opB;
			default: aluResult = fwdA + opB; // Unused codes add
		endcase
	end

	// Resolved here, two younger instructions get squashed
	assign redirect = idEx.jump || (idEx.branch && aluResult[0]);
	assign target = idEx.pcPlus4 + idEx.imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
		end else if (!memStall) begin
			exMem.regWrite <= idEx.regWrite;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.memToReg <= idEx.memToReg;
			exMem.aluResult <= aluResult;
			exMem.storeData <= fwdB;
			exMem.rd <= idEx.rd;
			exMem.width <= idEx.width;
		end
	end

endmodule

//--- hdl/memoryStage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module memoryStage (
	input  logic clk,
	input  logic reset,
	input  logic memStall,
	input  corePkg::exMemT exMem,
	input  logic [`XLEN-1:0] dmemRdata, // Same-cycle read data
	output corePkg::dmemReqT dmemReq,
	output logic wbEn,
	output logic [`REG_AW-1:0] wbRd,
	output logic [`XLEN-1:0] wbData
);
	import corePkg::*;

	logic [`XLEN-1:0] loadData;
	memWbT memWb;

	always_comb begin
		dmemReq.valid = exMem.memRead || exMem.memWrite;
		dmemReq.write = exMem.memWrite;
		dmemReq.addr = exMem.aluResult[`ADDR_W-1:0];
		dmemReq.wdata = exMem.storeData; // Sub-word data sits in the low lanes
		case (exMem.width)
			HALF:    dmemReq.byteEn = 4'b0011;
			BYTE:    dmemReq.byteEn = 4'b0001;
			default: dmemReq.byteEn = 4'b1111;
		endcase
	end

	// Zero-extend sub-word loads
	always_comb begin
		case (exMem.width)
			HALF:    loadData = {{(`XLEN-16){1'b0}}, dmemRdata[15:0]};
			BYTE:    loadData = {{(`XLEN-8){1'b0}}, dmemRdata[7:0]};
			default: loadData = dmemRdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb.regWrite <= 1'b0;
		end else if (!memStall) begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.aluResult <= exMem.aluResult;
			memWb.loadData <= loadData;
			memWb.rd <= exMem.rd;
		end
	end

	// Writeback select, also the forwarding source
	assign wbEn = memWb.regWrite;
	assign wbRd = memWb.rd;
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

//--- hdl/pipelineCore.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipelineCore (
	input  logic clk,
	input  logic reset,
	input  logic memStall, // Freezes everything, like a cache miss
	input  logic [`XLEN-1:0] imemData,
	input  logic [`XLEN-1:0] dmemRdata,
	output logic [`ADDR_W-1:0] imemAddr,
	output logic imemValid,
	output corePkg::dmemReqT dmemReq
);
	import corePkg::*;

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	logic stall; // Load-use hold
	logic redirect; // Doubles as squash
	logic [`XLEN-1:0] target;
	logic wbEn;
	logic [`REG_AW-1:0] wbRd;
	logic [`XLEN-1:0] wbData;

	fetchStage u_fetchStage (
		.clk(clk), .reset(reset), .memStall(memStall), .stall(stall),
		.redirect(redirect), .target(target), .imemData(imemData),
		.imemAddr(imemAddr), .imemValid(imemValid), .ifId(ifId)
	);

	decodeStage u_decodeStage (
		.clk(clk), .reset(reset), .memStall(memStall), .squash(redirect),
		.ifId(ifId), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
		.stall(stall), .idEx(idEx)
	);

	executeStage u_executeStage (
		.clk(clk), .reset(reset), .memStall(memStall), .idEx(idEx),
		.wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
		.redirect(redirect), .target(target), .exMem(exMem)
	);

	memoryStage u_memoryStage (
		.clk(clk), .reset(reset), .memStall(memStall), .exMem(exMem),
		.dmemRdata(dmemRdata), .dmemReq(dmemReq),
		.wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
	);

endmodule

//--- dv/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ALU sweep tables with entry k at bits [k*w +: w]
localparam logic [47:0] ALU_FN = {4'hF, 4'hD, 4'h9, 4'h8, 4'h7, 4'h6,
	4'h5, 4'h4, 4'h3, 4'h2, 4'h1, 4'h0};
localparam logic [59:0] ALU_SRC_A = {5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2,
	5'd1, 5'd2, 5'd2, 5'd2, 5'd1, 5'd1};
localparam logic [59:0] ALU_SRC_B = {5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1,
	5'd2, 5'd3, 5'd3, 5'd3, 5'd2, 5'd2};

// Register-register format with rs2 in 15:11
function automatic logic [31:0] rType(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [3:0] fn);
	return {OP_ALU, rd, rs1, rs2, 7'b0, fn};
endfunction

// Immediate format, store and branch keep the source in rd
function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm, input logic [3:0] fn);
	return {op, rd, rs1, imm, fn};
endfunction

task automatic emit(input logic [31:0] word);
	imem[progIdx] = word;
	progIdx++;
endtask

task automatic loadProgram();
	for (int i = 0; i < IMEM_WORDS; i++)
		imem[i] = {6'b0, 26'(i)}; // Opcode 0 no-op tagged with its word index
	progIdx = `PC_START / 4;
	// Test 2 operands 100, -8, 3
	emit(iType(OP_ALUI, 1, 0, 12'h064, ALU_ADD));
	emit(iType(OP_ALUI, 2, 0, 12'hFF8, ALU_ADD));
	emit(iType(OP_ALUI, 3, 0, 12'h003, ALU_ADD));
	for (int k = 0; k < 12; k++) begin
		emit(rType(4, ALU_SRC_A[5*k +: 5], ALU_SRC_B[5*k +: 5], ALU_FN[4*k +: 4]));
		emit(iType(OP_STORE, 4, 0, 12'(12'h100 + 4*k), 4'(WORD))); // Data via EX/MEM
	end
	// Test 3 forwarding chains
	emit(iType(OP_ALUI, 5, 0, 12'h007, ALU_ADD));
	emit(iType(OP_ALUI, 6, 0, 12'h005, ALU_ADD));
	emit(rType(7, 5, 6, ALU_ADD)); // r5 from MEM/WB, r6 from EX/MEM
	emit(rType(7, 7, 5, ALU_SUB));
	emit(iType(OP_STORE, 7, 0, 12'h140, 4'(WORD)));
	emit(iType(OP_ALUI, 0, 0, 12'h009, ALU_ADD)); // Write to r0 must vanish
	emit(rType(8, 0, 7, ALU_ADD));
	emit(iType(OP_STORE, 8, 0, 12'h144, 4'(WORD)));
	emit(iType(OP_ALUI, 9, 0, 12'h001, ALU_ADD));
	emit(iType(OP_ALUI, 9, 0, 12'h002, ALU_ADD)); // Younger value wins
	emit(rType(10, 9, 0, ALU_ADD));
	emit(iType(OP_STORE, 10, 0, 12'h148, 4'(WORD)));
	// Test 4 builds 07A5C8F3 then loads it back
	emit(iType(OP_ALUI, 11, 0, 12'h7A5, ALU_ADD));
	emit(iType(OP_ALUI, 11, 11, 12'h010, ALU_SLL));
	emit(iType(OP_ALUI, 12, 0, 12'h0C8, ALU_ADD));
	emit(iType(OP_ALUI, 12, 12, 12'h008, ALU_SLL));
	emit(iType(OP_ALUI, 12, 12, 12'h0F3, ALU_OR));
	emit(rType(11, 11, 12, ALU_OR));
	emit(iType(OP_STORE, 11, 0, 12'h200, 4'(WORD)));
	emit(iType(OP_LOAD, 13, 0, 12'h200, 4'(WORD)));
	emit(iType(OP_STORE, 13, 0, 12'h204, 4'(WORD))); // Load-use
	emit(iType(OP_LOAD, 14, 0, 12'h200, 4'(HALF)));
	emit(iType(OP_STORE, 14, 0, 12'h208, 4'(HALF)));
	emit(iType(OP_LOAD, 15, 0, 12'h200, 4'(BYTE)));
	emit(iType(OP_STORE, 15, 0, 12'h20C, 4'(BYTE)));
	emit(iType(OP_LOAD, 16, 0, 12'h200, 4'(BYTE)));
	emit(iType(OP_ALUI, 17, 16, 12'h001, ALU_ADD)); // ALU use of load
	emit(iType(OP_STORE, 17, 0, 12'h210, 4'(WORD)));
	// Test 5 control flow where stores to 3F0 must never show
	emit(iType(OP_ALUI, 18, 0, 12'h004, ALU_ADD));
	emit(iType(OP_BRANCH, 18, 18, 12'h008, ALU_EQ)); // Taken
	emit(iType(OP_STORE, 18, 0, 12'h3F0, 4'(WORD)));
	emit(iType(OP_STORE, 18, 0, 12'h3F0, 4'(WORD)));
	emit(iType(OP_STORE, 18, 0, 12'h300, 4'(WORD)));
	emit(iType(OP_BRANCH, 18, 18, 12'h008, ALU_NE)); // Falls through
	emit(iType(OP_STORE, 18, 0, 12'h304, 4'(WORD)));
	emit(iType(OP_JUMP, 0, 0, 12'h008, ALU_ADD));
	emit(iType(OP_STORE, 18, 0, 12'h3F0, 4'(WORD)));
	emit(iType(OP_STORE, 18, 0, 12'h3F0, 4'(WORD)));
	emit(iType(OP_STORE, 18, 0, 12'h308, 4'(WORD)));
	emit(iType(OP_STORE, 18, 0, 12'h7FC, 4'(WORD))); // End marker
	emit(iType(OP_JUMP, 0, 0, 12'hFFC, ALU_ADD)); // Spin on itself
endtask

task automatic addExpected(input int test, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] be);
	expTest[expCount] = test;
	expAddr[expCount] = addr;
	expData[expCount] = data;
	expBe[expCount] = be;
	expCount++;
endtask

// Hand-computed with unsigned compares giving bit 0
task automatic loadExpected();
	expCount = 0;
	addExpected(2, 16'h100, 32'h0000005C, 4'hF); // add
	addExpected(2, 16'h104, 32'h0000006C, 4'hF); // sub
	addExpected(2, 16'h108, 32'hFFFFFFC0, 4'hF); // sll
	addExpected(2, 16'h10C, 32'h1FFFFFFF, 4'hF); // srl
	addExpected(2, 16'h110, 32'hFFFFFFFF, 4'hF); // sra
	addExpected(2, 16'h114, 32'hFFFFFFFC, 4'hF); // or
	addExpected(2, 16'h118, 32'h00000001, 4'hF); // ge -8 vs 100
	addExpected(2, 16'h11C, 32'hFFFFFF9C, 4'hF); // xor
	addExpected(2, 16'h120, 32'h00000001, 4'hF); // slt
	addExpected(2, 16'h124, 32'h00000001, 4'hF); // eq
	addExpected(2, 16'h128, 32'h00000000, 4'hF); // ne
	addExpected(2, 16'h12C, 32'h00000060, 4'hF); // and
	addExpected(3, 16'h140, 32'h00000005, 4'hF);
	addExpected(3, 16'h144, 32'h00000005, 4'hF);
	addExpected(3, 16'h148, 32'h00000002, 4'hF);
	addExpected(4, 16'h200, 32'h07A5C8F3, 4'hF);
	addExpected(4, 16'h204, 32'h07A5C8F3, 4'hF);
	addExpected(4, 16'h208, 32'h0000C8F3, 4'h3);
	addExpected(4, 16'h20C, 32'h000000F3, 4'h1);
	addExpected(4, 16'h210, 32'h000000F4, 4'hF);
	addExpected(5, 16'h300, 32'h00000004, 4'hF);
	addExpected(5, 16'h304, 32'h00000004, 4'hF);
	addExpected(5, 16'h308, 32'h00000004, 4'hF);
	addExpected(5, 16'h7FC, 32'h00000004, 4'hF);
endtask

`endif

//--- dv/pipelineCoreTb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipelineCoreTb;
	import corePkg::*;

	localparam int CYCLE_LIMIT = 2000; // Two passes of ~100 cycles plus stall padding
	localparam int MAX_STORES = 32;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 1024;

	logic clk;
	logic reset;
	logic memStall;
	logic [`XLEN-1:0] imemData;
	logic [`XLEN-1:0] dmemRdata;
	logic [`ADDR_W-1:0] imemAddr;
	logic imemValid;
	dmemReqT dmemReq;

	logic [`XLEN-1:0] imem [IMEM_WORDS];
	logic [`XLEN-1:0] dmem [DMEM_WORDS];
	logic [`XLEN-1:0] imemWord;
	logic [`ADDR_W-1:0] expAddr [MAX_STORES];
	logic [`XLEN-1:0] expData [MAX_STORES];
	logic [3:0] expBe [MAX_STORES];
	int expTest [MAX_STORES];
	int expCount;
	int progIdx;
	int storeIdx; // Next expected store
	int cycles;
	int testErr [1:6];
	integer seed;
	logic stallOn;
	logic rerun; // Second pass under random stall
	logic storeAcc;

	`include "tbProgram.svh"

	pipelineCore u_pipelineCore (
		.clk(clk), .reset(reset), .memStall(memStall), .imemData(imemData),
		.dmemRdata(dmemRdata), .imemAddr(imemAddr), .imemValid(imemValid),
		.dmemReq(dmemReq)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory holds bytes little-endian for the core to swap back
	assign imemWord = imem[imemAddr[9:2]];
	assign imemData = {imemWord[7:0], imemWord[15:8], imemWord[23:16], imemWord[31:24]};
	assign dmemRdata = dmemReq.valid ? dmem[dmemReq.addr[11:2]] : '0;
	assign storeAcc = dmemReq.valid && dmemReq.write && !memStall; // Held request counts once

	always @(posedge clk) begin
		if (reset) begin
			storeIdx <= 0;
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= {16'hDA7A, 6'b0, i[9:0]}; // Word-address fill
		end else if (storeAcc) begin
			for (int b = 0; b < 4; b++)
				if (dmemReq.byteEn[b])
					dmem[dmemReq.addr[11:2]][8*b +: 8] <= dmemReq.wdata[8*b +: 8];
			storeIdx <= storeIdx + 1;
		end
	end

	// Quarter-duty random miss in the rerun only
	initial begin
		seed = 32'h28cc;
		memStall = 1'b0;
		@(posedge clk); // Past the time-0 clock transition
		forever begin
			@(negedge clk);
			memStall = stallOn && (($random(seed) & 3) == 0);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: program did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic noteError(input int idx);
		int t;
		t = rerun ? 6 : expTest[(idx < expCount) ? idx : expCount - 1];
		testErr[t]++;
	endtask

	assert property (@(posedge clk) disable iff (reset) storeAcc |-> storeIdx < expCount)
		else begin
			noteError($sampled(storeIdx));
			$display("Unexpected extra store at %0t to address %h", $time, $sampled(dmemReq.addr));
		end

	assert property (@(posedge clk) disable iff (reset)
			storeAcc && storeIdx < expCount |-> dmemReq.addr == expAddr[storeIdx])
		else begin
			noteError($sampled(storeIdx));
			$display("[ERROR] %0t dmemReq.addr got %h expected %h", $time,
				$sampled(dmemReq.addr), expAddr[$sampled(storeIdx)]);
		end

	assert property (@(posedge clk) disable iff (reset)
			storeAcc && storeIdx < expCount |-> dmemReq.wdata == expData[storeIdx])
		else begin
			noteError($sampled(storeIdx));
			$display("[ERROR] %0t dmemReq.wdata got %h expected %h", $time,
				$sampled(dmemReq.wdata), expData[$sampled(storeIdx)]);
		end

	assert property (@(posedge clk) disable iff (reset)
			storeAcc && storeIdx < expCount |-> dmemReq.byteEn == expBe[storeIdx])
		else begin
			noteError($sampled(storeIdx));
			$display("[ERROR] %0t dmemReq.byteEn got %b expected %b", $time,
				$sampled(dmemReq.byteEn), expBe[$sampled(storeIdx)]);
		end

	function automatic string testName(input int t);
		case (t)
			1: return "reset state";
			2: return "ALU functions";
			3: return "forwarding";
			4: return "loads and load-use";
			5: return "branch and jump";
			default: return "random memStall rerun";
		endcase
	endfunction

	task automatic reportTest(input int t);
		$display("Test %0d (%s): %0d error(s), %s", t, testName(t), testErr[t],
			(testErr[t] == 0) ? "ok" : "FAILED");
	endtask

	// Follows the store stream and reports each test as its last store lands
	task automatic runProgram();
		int seen;
		seen = 0;
		while (seen < expCount) begin
			@(negedge clk);
			if (storeIdx != seen) begin
				seen = storeIdx;
				if (!rerun && seen < expCount && expTest[seen] != expTest[seen-1])
					reportTest(expTest[seen-1]);
			end
		end
		repeat (8) @(negedge clk); // Squashed stores would surface here
		if (!rerun)
			reportTest(expTest[expCount-1]);
	endtask

	initial begin
		int totalErr;
		int failedTests;
		reset = 1'b1;
		stallOn = 1'b0;
		rerun = 1'b0;
		loadProgram();
		loadExpected();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (imemAddr == `ADDR_W'(`PC_START))
			else begin
				testErr[1]++;
				$display("[ERROR] %0t imemAddr got %h expected %h", $time, imemAddr,
					`ADDR_W'(`PC_START));
			end
		assert (!dmemReq.valid)
			else begin
				testErr[1]++;
				$display("[ERROR] %0t dmemReq.valid got %b expected 0", $time, dmemReq.valid);
			end
		assert (!imemValid)
			else begin
				testErr[1]++;
				$display("[ERROR] %0t imemValid got %b expected 0", $time, imemValid);
			end
		@(negedge clk);
		assert (imemValid)
			else begin
				testErr[1]++;
				$display("[ERROR] %0t imemValid got %b expected 1", $time, imemValid);
			end
		reportTest(1);
		runProgram();
		@(negedge clk);
		reset = 1'b1; // Same program again with misses
		rerun = 1'b1;
		stallOn = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		runProgram();
		reportTest(6);
		totalErr = 0;
		failedTests = 0;
		for (int t = 1; t <= 6; t++) begin
			totalErr += testErr[t];
			if (testErr[t] != 0)
				failedTests++;
		end
		$display("Summary: 6 tests, %0d failed, %0d errors, %0d cycles", failedTests,
			totalErr, cycles);
		if (totalErr == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+hdl
+incdir+dv
hdl/corePkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipelineCore.sv
dv/pipelineCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipelineCore testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipelineCoreTb \
	-f verilog.f -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0
